//--- design/dm_pkg.sv
// DMI and SBA definitions; 32-bit system bus accesses only, DMI responses always report success
package dm_pkg;

   // DMI operation codes as seen by the debug transport
   typedef enum logic [1:0] {
      DmiRead  = 2'd1,
      DmiWrite = 2'd2
   } dmi_op_e;

   typedef struct packed {
      logic [6:0]  addr;
      dmi_op_e     op;
      logic [31:0] data;
   } dmi_req_t;

   typedef struct packed {
      logic [31:0] data;
      logic [1:0]  resp;
   } dmi_rsp_t;

   localparam logic [1:0] DmiRespSuccess = 2'd0;

   // Debug module register map
   localparam logic [6:0] DmControlAddr  = 7'h10;
   localparam logic [6:0] SbcsAddr       = 7'h38;
   localparam logic [6:0] SbAddress0Addr = 7'h39;
   localparam logic [6:0] SbData0Addr    = 7'h3C;

   // Fixed SBCS capabilities
   localparam logic [2:0] SbVersion  = 3'd1;
   localparam logic [6:0] SbAsize    = 7'd32;
   localparam logic [2:0] SbAccess32 = 3'd2;

   // SBCS layout, bit 31 first
   typedef struct packed {
      logic [2:0] sbversion;
      logic [5:0] zero1;
      logic       sbbusyerror;
      logic       sbbusy;
      logic       sbreadonaddr;
      logic [2:0] sbaccess;
      logic       sbautoincrement;
      logic       sbreadondata;
      logic [2:0] sberror;
      logic [6:0] sbasize;
      logic [4:0] zero0;
   } sbcs_t;

   typedef enum logic [2:0] {
      SbErrNone    = 3'd0,
      SbErrBadAddr = 3'd2,
      SbErrBadSize = 3'd4
   } sb_err_e;

   typedef enum logic [1:0] {
      SbaSetAddr,
      SbaSetAddrRead,
      SbaWriteData,
      SbaReadNext
   } sba_cmd_e;

   typedef struct packed {
      sba_cmd_e    kind;
      logic [31:0] data;
      logic        autoinc;
      logic [2:0]  access;
   } sba_cmd_t;

   // Error is a one-cycle pulse; front end keeps the sticky copy
   typedef struct packed {
      logic        busy;
      sb_err_e     err;
      logic [31:0] addr;
      logic [31:0] rdata;
   } sba_status_t;

endpackage

//--- design/sysbus_pkg.sv
// System bus types; one word per access, fixed one-cycle slave latency, no byte enables
package sysbus_pkg;

   // Memory geometry, MemWords must equal 2**MemAddrBits
   localparam int MemWords    = 256;
   localparam int MemAddrBits = 8;

   // Byte offset bits within a 32-bit word
   localparam int ByteOffBits = 2;

   // Address is a byte address, low two bits ignored by the slave
   typedef struct packed {
      logic        we;
      logic [31:0] addr;
      logic [31:0] wdata;
   } sbus_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        err;
   } sbus_rsp_t;

endpackage

//--- design/dmi_front.sv
// DMI register front end; no back-pressure, one request per cycle, response always one cycle later
`timescale 1ns/10ps

module dmi_front import dm_pkg::*; (
   input  logic        clk_sys,
   input  logic        rst_i,
   input  logic        dmi_req_valid_i,
   input  dmi_req_t    dmi_req_i,
   output logic        dmi_rsp_valid_o,
   output dmi_rsp_t    dmi_rsp_o,
   output logic        sba_cmd_valid_o,
   output sba_cmd_t    sba_cmd_o,
   input  sba_status_t sba_status_i
);

   // Writable SBCS fields and DMControl
   logic       dmactive_q;
   logic       sbreadonaddr_q;
   logic [2:0] sbaccess_q;
   logic       sbautoinc_q;
   logic       sbreadondata_q;
   logic [2:0] sberror_q;
   logic       sbbusyerror_q;

   logic        rsp_valid_q;
   logic [31:0] rsp_data_q;

   logic        req_rd;
   logic        req_wr;
   logic        sb_access;
   sba_cmd_e    sb_kind;
   sbcs_t       sbcs_wr;
   sbcs_t       sbcs_rd;
   logic [31:0] rd_data;

   assign req_rd  = dmi_req_valid_i && (dmi_req_i.op == DmiRead);
   assign req_wr  = dmi_req_valid_i && (dmi_req_i.op == DmiWrite);
   assign sbcs_wr = sbcs_t'(dmi_req_i.data);

   // Which DMI accesses start a bus access
   always_comb begin
      sb_access = 1'b0;
      sb_kind   = SbaSetAddr;
      if (req_wr && dmi_req_i.addr == SbAddress0Addr) begin
         sb_access = 1'b1;
         sb_kind   = sbreadonaddr_q ? SbaSetAddrRead : SbaSetAddr;
      end else if (req_wr && dmi_req_i.addr == SbData0Addr) begin
         sb_access = 1'b1;
         sb_kind   = SbaWriteData;
      end else if (req_rd && dmi_req_i.addr == SbData0Addr && sbreadondata_q) begin
         sb_access = 1'b1;
         sb_kind   = SbaReadNext;
      end
   end

   // Refused while the engine is busy
   assign sba_cmd_valid_o   = sb_access && !sba_status_i.busy;
   assign sba_cmd_o.kind    = sb_kind;
   assign sba_cmd_o.data    = dmi_req_i.data;
   assign sba_cmd_o.autoinc = sbautoinc_q;
   assign sba_cmd_o.access  = sbaccess_q;

   // SBCS as seen by the debugger, busy taken live from the engine
   always_comb begin
      sbcs_rd                 = '0;
      sbcs_rd.sbversion       = SbVersion;
      sbcs_rd.sbbusyerror     = sbbusyerror_q;
      sbcs_rd.sbbusy          = sba_status_i.busy;
      sbcs_rd.sbreadonaddr    = sbreadonaddr_q;
      sbcs_rd.sbaccess        = sbaccess_q;
      sbcs_rd.sbautoincrement = sbautoinc_q;
      sbcs_rd.sbreadondata    = sbreadondata_q;
      sbcs_rd.sberror         = sberror_q;
      sbcs_rd.sbasize         = SbAsize;
   end

   // Read mux, also used as the response to writes
   always_comb begin
      case (dmi_req_i.addr)
         DmControlAddr:  rd_data = {31'b0, dmactive_q};
         SbcsAddr:       rd_data = sbcs_rd;
         SbAddress0Addr: rd_data = sba_status_i.addr;
         SbData0Addr:    rd_data = sba_status_i.rdata;
         default:        rd_data = '0;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         rsp_valid_q    <= 1'b0;
         dmactive_q     <= 1'b0;
         sbreadonaddr_q <= 1'b0;
         sbaccess_q     <= 3'd0;
         sbautoinc_q    <= 1'b0;
         sbreadondata_q <= 1'b0;
         sberror_q      <= 3'd0;
         sbbusyerror_q  <= 1'b0;
      end else begin
         rsp_valid_q <= dmi_req_valid_i;
         if (req_wr && dmi_req_i.addr == DmControlAddr) begin
            dmactive_q <= dmi_req_i.data[0];
         end
         if (req_wr && dmi_req_i.addr == SbcsAddr) begin
            sbreadonaddr_q <= sbcs_wr.sbreadonaddr;
            sbaccess_q     <= sbcs_wr.sbaccess;
            sbautoinc_q    <= sbcs_wr.sbautoincrement;
            sbreadondata_q <= sbcs_wr.sbreadondata;
         end
         // New error pulse wins over a clear in the same cycle
         if (sba_status_i.err != SbErrNone) begin
            sberror_q <= sba_status_i.err;
         end else if (req_wr && dmi_req_i.addr == SbcsAddr) begin
            sberror_q <= sberror_q & ~sbcs_wr.sberror;
         end
         if (sb_access && sba_status_i.busy) begin
            sbbusyerror_q <= 1'b1;
         end else if (req_wr && dmi_req_i.addr == SbcsAddr && sbcs_wr.sbbusyerror) begin
            sbbusyerror_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_req_valid_i) begin
         rsp_data_q <= rd_data;
      end
   end

   assign dmi_rsp_valid_o = rsp_valid_q;
   assign dmi_rsp_o.data  = rsp_data_q;
   assign dmi_rsp_o.resp  = DmiRespSuccess;

endmodule

//--- design/sba_engine.sv
// Bus access engine; one transaction at a time, commands accepted only while idle, 32-bit only
`timescale 1ns/10ps

module sba_engine import dm_pkg::*, sysbus_pkg::*; (
   input  logic        clk_sys,
   input  logic        rst_i,
   input  logic        sba_cmd_valid_i,
   input  sba_cmd_t    sba_cmd_i,
   output sba_status_t sba_status_o,
   output logic        bus_req_valid_o,
   output sbus_req_t   bus_req_o,
   input  logic        bus_rsp_valid_i,
   input  sbus_rsp_t   bus_rsp_i
);

   typedef enum logic [1:0] {
      StIdle,
      StReq,
      StWait,
      StDone
   } state_e;

   state_e      state_q;
   sb_err_e     err_q;
   logic [31:0] addr_q;
   logic [31:0] data_q;
   logic        we_q;
   logic        autoinc_q;

   logic cmd_take;
   logic cmd_bus;
   logic size_ok;

   assign cmd_take = sba_cmd_valid_i && (state_q == StIdle);
   // Only a plain address load stays off the bus
   assign cmd_bus  = (sba_cmd_i.kind != SbaSetAddr);
   assign size_ok  = (sba_cmd_i.access == SbAccess32);

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         state_q <= StIdle;
         err_q   <= SbErrNone;
         addr_q  <= '0;
         data_q  <= '0;
      end else begin
         err_q <= SbErrNone;
         case (state_q)
            StIdle: begin
               if (cmd_take) begin
                  if (sba_cmd_i.kind == SbaSetAddr || sba_cmd_i.kind == SbaSetAddrRead) begin
                     addr_q <= sba_cmd_i.data;
                  end
                  if (sba_cmd_i.kind == SbaWriteData) begin
                     data_q <= sba_cmd_i.data;
                  end
                  if (cmd_bus) begin
                     if (size_ok) begin
                        state_q <= StReq;
                     end else begin
                        err_q <= SbErrBadSize;
                     end
                  end
               end
            end
            StReq: begin
               state_q <= StWait;
            end
            StWait: begin
               if (bus_rsp_valid_i) begin
                  if (bus_rsp_i.err) begin
                     err_q <= SbErrBadAddr;
                  end else begin
                     if (!we_q) begin
                        data_q <= bus_rsp_i.rdata;
                     end
                     // Step to the next word only on success
                     if (autoinc_q) begin
                        addr_q <= addr_q + 32'd4;
                     end
                  end
                  state_q <= StDone;
               end
            end
            default: begin
               state_q <= StIdle;
            end
         endcase
      end
   end

   // Access attributes of the transaction in flight
   always_ff @(posedge clk_sys) begin
      if (cmd_take) begin
         we_q      <= (sba_cmd_i.kind == SbaWriteData);
         autoinc_q <= sba_cmd_i.autoinc;
      end
   end

   assign bus_req_valid_o = (state_q == StReq);
   assign bus_req_o.we    = we_q;
   assign bus_req_o.addr  = addr_q;
   assign bus_req_o.wdata = data_q;

   assign sba_status_o.busy  = (state_q != StIdle);
   assign sba_status_o.err   = err_q;
   assign sba_status_o.addr  = addr_q;
   assign sba_status_o.rdata = data_q;

endmodule

//--- design/sys_sram.sv
// Word memory; contents not reset, out-of-range accesses answer with an error and write nothing
`timescale 1ns/10ps

module sys_sram import sysbus_pkg::*; (
   input  logic      clk_sys,
   input  logic      rst_i,
   input  logic      bus_req_valid_i,
   input  sbus_req_t bus_req_i,
   output logic      bus_rsp_valid_o,
   output sbus_rsp_t bus_rsp_o
);

   logic [31:0] mem [MemWords];

   logic                   rsp_valid_q;
   logic [31:0]            rdata_q;
   logic                   err_q;
   logic [MemAddrBits-1:0] idx;
   logic                   in_range;

   // Word index drops the byte offset
   assign idx      = bus_req_i.addr[MemAddrBits+ByteOffBits-1:ByteOffBits];
   assign in_range = (bus_req_i.addr < 32'(MemWords * 4));

   always_ff @(posedge clk_sys) begin
      if (rst_i) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= bus_req_valid_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (bus_req_valid_i) begin
         if (in_range && bus_req_i.we) begin
            mem[idx] <= bus_req_i.wdata;
         end
         // Returns the old word on a write
         rdata_q <= in_range ? mem[idx] : '0;
         err_q   <= !in_range;
      end
   end

   assign bus_rsp_valid_o = rsp_valid_q;
   assign bus_rsp_o.rdata = rdata_q;
   assign bus_rsp_o.err   = err_q;

endmodule

//--- design/dm_sba_top.sv
// System bus access top; DMI requests must be single-cycle strobes with at most one per cycle
`timescale 1ns/10ps

module dm_sba_top import dm_pkg::*, sysbus_pkg::*; (
   input  logic     clk_sys,
   input  logic     rst_i,
   input  logic     dmi_req_valid_i,
   input  dmi_req_t dmi_req_i,
   output logic     dmi_rsp_valid_o,
   output dmi_rsp_t dmi_rsp_o
);

   logic        sba_cmd_valid;
   sba_cmd_t    sba_cmd;
   sba_status_t sba_status;

   logic        bus_req_valid;
   sbus_req_t   bus_req;
   logic        bus_rsp_valid;
   sbus_rsp_t   bus_rsp;

   dmi_front i_dmi_front (
      .clk_sys         (clk_sys),
      .rst_i           (rst_i),
      .dmi_req_valid_i (dmi_req_valid_i),
      .dmi_req_i       (dmi_req_i),
      .dmi_rsp_valid_o (dmi_rsp_valid_o),
      .dmi_rsp_o       (dmi_rsp_o),
      .sba_cmd_valid_o (sba_cmd_valid),
      .sba_cmd_o       (sba_cmd),
      .sba_status_i    (sba_status)
   );

   sba_engine i_sba_engine (
      .clk_sys         (clk_sys),
      .rst_i           (rst_i),
      .sba_cmd_valid_i (sba_cmd_valid),
      .sba_cmd_i       (sba_cmd),
      .sba_status_o    (sba_status),
      .bus_req_valid_o (bus_req_valid),
      .bus_req_o       (bus_req),
      .bus_rsp_valid_i (bus_rsp_valid),
      .bus_rsp_i       (bus_rsp)
   );

   sys_sram i_sys_sram (
      .clk_sys         (clk_sys),
      .rst_i           (rst_i),
      .bus_req_valid_i (bus_req_valid),
      .bus_req_i       (bus_req),
      .bus_rsp_valid_o (bus_rsp_valid),
      .bus_rsp_o       (bus_rsp)
   );

endmodule

//--- sim/dm_sba_assert.sv
// Bound to dmi_front; sees only the front end ports, so bus overlap is checked through busy
`timescale 1ns/10ps

module dm_sba_assert import dm_pkg::*; (
   input logic        clk_sys,
   input logic        rst_i,
   input logic        dmi_req_valid_i,
   input logic        dmi_rsp_valid_o,
   input logic        sba_cmd_valid_o,
   input sba_cmd_t    sba_cmd_o,
   input sba_status_t sba_status_i
);

   // Failed assertion count, read by the testbench at the end of the run
   int fail_cnt = 0;

   // Response exactly one cycle after each request
   a_rsp_follows_req: assert property (@(posedge clk_sys) disable iff (rst_i)
      dmi_req_valid_i |=> dmi_rsp_valid_o)
      else begin
         $error("DMI request without a response in the next cycle");
         fail_cnt = fail_cnt + 1;
      end

   a_no_rsp_without_req: assert property (@(posedge clk_sys) disable iff (rst_i)
      !dmi_req_valid_i |=> !dmi_rsp_valid_o)
      else begin
         $error("DMI response without a request in the cycle before");
         fail_cnt = fail_cnt + 1;
      end

   a_no_cmd_while_busy: assert property (@(posedge clk_sys) disable iff (rst_i)
      sba_cmd_valid_o |-> !sba_status_i.busy)
      else begin
         $error("SBA command sent while the engine is busy");
         fail_cnt = fail_cnt + 1;
      end

   // Busy held after a started access keeps a second bus request out
   a_bus_access_busy: assert property (@(posedge clk_sys) disable iff (rst_i)
      (sba_cmd_valid_o && sba_cmd_o.kind != SbaSetAddr && sba_cmd_o.access == SbAccess32)
      |=> sba_status_i.busy)
      else begin
         $error("Bus access started without busy, a second request could overlap");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind dmi_front dm_sba_assert i_dm_sba_assert (
   .clk_sys         (clk_sys),
   .rst_i           (rst_i),
   .dmi_req_valid_i (dmi_req_valid_i),
   .dmi_rsp_valid_o (dmi_rsp_valid_o),
   .sba_cmd_valid_o (sba_cmd_valid_o),
   .sba_cmd_o       (sba_cmd_o),
   .sba_status_i    (sba_status_i)
);

//--- sim/dm_sba_tb.sv
// Case-file driven testbench; run from the project root so that sim/dm_sba_cases.txt is found
`timescale 1ns/10ps

module dm_sba_tb import dm_pkg::*; ();

   // One line of the case file
   typedef struct packed {
      logic [15:0] test;
      logic [31:0] kind;
      logic [6:0]  addr;
      logic [31:0] data;
      logic [31:0] exp_data;
      logic [31:0] mask;
   } case_t;

   logic     clk_sys;
   logic     rst_i;
   logic     dmi_req_valid;
   dmi_req_t dmi_req;
   logic     dmi_rsp_valid;
   dmi_rsp_t dmi_rsp;

   case_t cases[$];
   bit    loaded;
   int    cur_test;
   int    test_errs;
   int    tests;
   int    checks;
   int    errors;

   dm_sba_top i_dut (
      .clk_sys         (clk_sys),
      .rst_i           (rst_i),
      .dmi_req_valid_i (dmi_req_valid),
      .dmi_req_i       (dmi_req),
      .dmi_rsp_valid_o (dmi_rsp_valid),
      .dmi_rsp_o       (dmi_rsp)
   );

   always #2 clk_sys = ~clk_sys;

   task automatic load_cases(output bit ok);
      int          fd;
      int          n;
      int          t;
      logic [31:0] k;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;
      logic [31:0] m;
      string       line;
      case_t       c;
      fd = $fopen("sim/dm_sba_cases.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Header and blank lines fail the column match
            if (n > 0 && $sscanf(line, "%d %s %h %h %h %h", t, k, a, d, e, m) == 6) begin
               c.test     = 16'(t);
               c.kind     = k;
               c.addr     = a[6:0];
               c.data     = d;
               c.exp_data = e;
               c.mask     = m;
               cases.push_back(c);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_dmi_rsp(input dmi_rsp_t got, input dmi_rsp_t exp, input logic [31:0] mask);
      checks++;
      if (((got.data ^ exp.data) & mask) != 32'd0) begin
         errors++;
         test_errs++;
         $display("** Error: dmi_rsp_o.data got %h expected %h mask %h", got.data, exp.data, mask);
      end
      if (got.resp != exp.resp) begin
         errors++;
         test_errs++;
         $display("** Error: dmi_rsp_o.resp got %h expected %h", got.resp, exp.resp);
      end
   endtask

   task automatic check_sbcs(input sbcs_t got, input sbcs_t exp, input logic [31:0] mask);
      checks++;
      if (((got ^ exp) & mask) != 32'd0) begin
         errors++;
         test_errs++;
         $display("** Error: sbcs got %h expected %h (sberror %h/%h, sbbusyerror %h/%h)",
                  got, exp, got.sberror, exp.sberror, got.sbbusyerror, exp.sbbusyerror);
      end
   endtask

   // One DMI request strobe and the wait for its response
   task automatic dmi_access(input dmi_op_e op, input logic [6:0] addr, input logic [31:0] data,
                             output dmi_rsp_t rsp, output bit ok);
      int waited;
      @(posedge clk_sys);
      dmi_req_valid <= 1'b1;
      dmi_req.addr  <= addr;
      dmi_req.op    <= op;
      dmi_req.data  <= data;
      @(posedge clk_sys);
      dmi_req_valid <= 1'b0;
      ok     = 1'b0;
      waited = 0;
      // Sampled mid-cycle
      while (!ok && waited < 4) begin
         @(negedge clk_sys);
         ok     = dmi_rsp_valid;
         waited = waited + 1;
      end
      rsp = dmi_rsp;
      if (!ok) begin
         errors++;
         test_errs++;
         $display("test %0d: no DMI response within 4 cycles of the request", cur_test);
      end
   endtask

   task automatic run_case(input case_t c);
      dmi_rsp_t rsp;
      dmi_rsp_t exp;
      sbcs_t    sbcs;
      dmi_op_e  op;
      bit       ok;
      int       polls;
      exp.data = c.exp_data;
      exp.resp = DmiRespSuccess;
      if (c.kind == "poll") begin
         polls = 0;
         do begin
            dmi_access(DmiRead, SbcsAddr, 32'd0, rsp, ok);
            sbcs  = rsp.data;
            polls = polls + 1;
         end while (ok && sbcs.sbbusy && polls < 50);
         if (ok && sbcs.sbbusy) begin
            errors++;
            test_errs++;
            $display("test %0d: sbbusy still set after 50 SBCS reads", cur_test);
         end else if (ok) begin
            check_sbcs(sbcs, c.exp_data, c.mask);
         end
      end else begin
         if (c.kind == "wr") begin
            op = DmiWrite;
         end else begin
            op = DmiRead;
         end
         dmi_access(op, c.addr, c.data, rsp, ok);
         if (ok && c.addr == SbcsAddr) begin
            check_sbcs(rsp.data, c.exp_data, c.mask);
         end else if (ok) begin
            check_dmi_rsp(rsp, exp, c.mask);
         end
      end
   endtask

   task automatic report_test();
      tests++;
      if (test_errs == 0) begin
         $display("test %0d: passed", cur_test);
      end else begin
         $display("test %0d: failed with %0d errors", cur_test, test_errs);
      end
      test_errs = 0;
   endtask

   initial begin
      bit ok;
      int asrt_fails;
      clk_sys       = 1'b0;
      rst_i         = 1'b1;
      dmi_req_valid = 1'b0;
      dmi_req       = '0;
      loaded        = 1'b0;
      test_errs     = 0;
      tests         = 0;
      checks        = 0;
      errors        = 0;
      load_cases(ok);
      if (!ok || cases.size() == 0) begin
         $display("Could not read any case from sim/dm_sba_cases.txt");
         $display("STATUS: FAIL");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (10) @(posedge clk_sys);
         rst_i    <= 1'b0;
         cur_test = cases[0].test;
         foreach (cases[i]) begin
            if (cases[i].test != cur_test) begin
               report_test();
               cur_test = cases[i].test;
            end
            run_case(cases[i]);
         end
         report_test();
         asrt_fails = i_dut.i_dmi_front.i_dm_sba_assert.fail_cnt;
         if (asrt_fails != 0) begin
            $display("Bound assertions failed %0d times during the run", asrt_fails);
         end
         errors = errors + asrt_fails;
         $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
         if (errors == 0) begin
            $display("STATUS: PASS");
         end else begin
            $display("STATUS: FAIL");
         end
         $finish;
      end
   end

   // Budget of 60 cycles per case line plus reset
   initial begin
      wait (loaded);
      repeat (cases.size() * 60 + 20) @(posedge clk_sys);
      $display("Watchdog expired, cases did not finish within %0d cycles", cases.size() * 60 + 20);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- sim/dm_sba_cases.txt
# test kind addr data expect mask (kind rd, wr or poll; poll reads SBCS until sbbusy clears)
# addr, data, expect and mask in hex; mask 0 ignores the response of that line
1 rd   38 00000000 20000400 ffffffff
1 wr   10 00000001 00000000 00000000
1 rd   10 00000000 00000001 ffffffff
2 wr   38 00050000 00000000 00000000
2 rd   38 00000000 20050400 ffffffff
2 wr   39 00000100 00000000 00000000
2 wr   3c 3a5c0100 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c 71e20104 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c 9b0d0108 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c c4f7010c 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c 0e6a0110 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c 58b30114 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c a21f0118 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 wr   3c ed84011c 00000000 00000000
2 poll 38 00000000 20050400 ffffffff
2 rd   39 00000000 00000120 ffffffff
3 wr   38 00158000 00000000 00000000
3 wr   39 00000100 00000000 00000000
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 3a5c0100 ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 71e20104 ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 9b0d0108 ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 c4f7010c ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 0e6a0110 ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 58b30114 ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 a21f0118 ffffffff
3 poll 38 00000000 20158400 ffffffff
3 rd   3c 00000000 ed84011c ffffffff
3 poll 38 00000000 20158400 ffffffff
4 wr   3c 0badf00d 00000000 00000000
4 wr   3c 0badf00e 00000000 00000000
4 poll 38 00000000 20558400 ffffffff
4 wr   38 00558000 00000000 00000000
4 rd   38 00000000 20158400 ffffffff
5 wr   39 00000400 00000000 00000000
5 poll 38 00000000 2015a400 ffffffff
5 wr   38 0015f000 00000000 00000000
5 wr   38 00010000 00000000 00000000
5 wr   3c 12345678 00000000 00000000
5 rd   38 00000000 20014400 ffffffff
5 wr   38 0015f000 00000000 00000000
5 wr   39 00000104 00000000 00000000
5 poll 38 00000000 20158400 ffffffff
5 rd   3c 00000000 71e20104 ffffffff
5 poll 38 00000000 20158400 ffffffff

//--- sources.f
design/dm_pkg.sv
design/sysbus_pkg.sv
design/dmi_front.sv
design/sba_engine.sv
design/sys_sram.sv
design/dm_sba_top.sv
sim/dm_sba_assert.sv
sim/dm_sba_tb.sv
